/* filelist.f */
+incdir+.
hl_pkg.sv
hl_packet_classifier.sv
hl_cmd_extractor.sv
hl_cmd_regs.sv
hl_ctrl_top.sv
tb_hl_ctrl.sv

/* Makefile */
# Verilator flow for the control path testbench

TOP := tb_hl_ctrl

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing -f filelist.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -f filelist.f --top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP)

clean:
	rm -rf obj_dir

/* tb_hl_ctrl.sv */
/*
  Testbench for the control path top level. Sends random data, start/stop,
  discovery and malformed packets, mirrors the command registers in a model
  and checks responses, run levels, transmit-on and the watchdog.
*/
`timescale 1ns/1ps
`include "hl_cfg.svh"

module tb_hl_ctrl;

  import hl_pkg::*;

  localparam int PKT_LEN  = `HL_HDR_LEN + `HL_NUM_FRAMES * `HL_FRAME_LEN;
  localparam int WAIT_MAX = 16;
  localparam int WD       = `HL_WATCHDOG_CYCLES;

  logic        clk_ctrl;
  logic        rst_i;
  logic        udp_rx_active_i;
  byte_t       udp_rx_data_i;
  logic        run_o;
  logic        wide_spectrum_o;
  logic        discovery_o;
  logic        tx_on_o;
  resp_t       resp_o;
  logic        resp_rqst_o;

  logic [31:0] lcg_state;
  byte_t       pkt [PKT_LEN];
  int          pkt_len;
  cmd_data_t   model_regs [`HL_NUM_REGS];
  logic        model_run;
  logic        model_wide;
  logic        model_ptt;
  resp_t       exp_q [$];
  int          disc_seen;
  int          disc_expected;
  logic        probe_pending;
  cmd_addr_t   probe_addr;

  hl_ctrl_top i_hl_ctrl_top (
    .clk_ctrl        (clk_ctrl),
    .rst_i           (rst_i),
    .udp_rx_active_i (udp_rx_active_i),
    .udp_rx_data_i   (udp_rx_data_i),
    .run_o           (run_o),
    .wide_spectrum_o (wide_spectrum_o),
    .discovery_o     (discovery_o),
    .tx_on_o         (tx_on_o),
    .resp_o          (resp_o),
    .resp_rqst_o     (resp_rqst_o)
  );

  always #2 clk_ctrl = ~clk_ctrl;

  function automatic logic [31:0] rand_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  task automatic stop_with_failure(input string why);
    $display("%s", why);
    $display("Test failed");
    $fatal(1, "simulation stopped on first error");
  endtask

  task automatic check_value(input string name, input logic [63:0] got,
                             input logic [63:0] exp);
    assert (got === exp) else begin
      stop_with_failure($sformatf("[FAIL] time %0t: %s = %0h, expected %0h",
                                  $time, name, got, exp));
    end
  endtask

  task automatic check_outputs_low();
    check_value("run_o", 64'(run_o), 64'(0));
    check_value("wide_spectrum_o", 64'(wide_spectrum_o), 64'(0));
    check_value("discovery_o", 64'(discovery_o), 64'(0));
    check_value("tx_on_o", 64'(tx_on_o), 64'(0));
    check_value("resp_rqst_o", 64'(resp_rqst_o), 64'(0));
  endtask

  ////////////////////
  // Monitor

  // Pulses sampled on the falling edge away from the DUT updates
  always @(negedge clk_ctrl) begin
    if (!rst_i) begin
      if (discovery_o) begin
        disc_seen++;
      end
      if (resp_rqst_o) begin
        assert (exp_q.size() != 0) else begin
          stop_with_failure("Response request pulse for a command that asked for none");
        end
        check_value("resp_o", 64'(resp_o), 64'(exp_q.pop_front()));
      end
    end
  end

  ////////////////////
  // Packet stimulus

  task automatic drive_packet();
    for (int i = 0; i < pkt_len; i++) begin
      @(posedge clk_ctrl);
      #1;
      udp_rx_active_i = 1'b1;
      udp_rx_data_i   = pkt[i];
    end
    @(posedge clk_ctrl);
    #1;
    udp_rx_active_i = 1'b0;
    udp_rx_data_i   = '0;
  endtask

  // Header plus two USB frames
  // Model follows only the accepted commands
  task automatic build_data(input logic good_hdr);
    logic [31:0] r;
    logic        bad_sync;
    logic        req;
    logic        ptt;
    cmd_addr_t   addr;
    cmd_data_t   data;
    int          base;
    pkt_len = PKT_LEN;
    pkt[0]  = `HL_MAGIC0;
    pkt[1]  = `HL_MAGIC1;
    pkt[2]  = `HL_TYPE_DATA;
    pkt[3]  = `HL_EP_DATA;
    for (int i = 4; i < `HL_HDR_LEN; i++) begin
      pkt[i] = byte_t'(rand_next() >> 24);
    end
    if (!good_hdr) begin
      r = rand_next();
      case (r[31:30])
        2'd0:    pkt[0] = 8'hEE;
        2'd1:    pkt[1] = 8'hFF;
        2'd2:    pkt[2] = 8'h03;
        default: pkt[3] = 8'h03;
      endcase
    end
    for (int f = 0; f < `HL_NUM_FRAMES; f++) begin
      base     = `HL_HDR_LEN + f * `HL_FRAME_LEN;
      r        = rand_next();
      addr     = cmd_addr_t'(r >> 26);
      req      = r[25];
      ptt      = r[24];
      bad_sync = (r[23:22] == 2'b00);
      // Read back an address whose write was dropped earlier
      if (good_hdr && !bad_sync && probe_pending && f == 0) begin
        addr          = probe_addr;
        req           = 1'b1;
        probe_pending = 1'b0;
      end
      data = rand_next();
      for (int i = 0; i < 3; i++) begin
        pkt[base + i] = `HL_SYNC_BYTE;
      end
      if (bad_sync) begin
        pkt[base + int'(r[21:20]) % 3] = `HL_SYNC_BYTE ^ 8'h10;
      end
      pkt[base + 3] = {req, addr, ptt};
      pkt[base + 4] = data[31:24];
      pkt[base + 5] = data[23:16];
      pkt[base + 6] = data[15:8];
      pkt[base + 7] = data[7:0];
      for (int i = 8; i < `HL_FRAME_LEN; i++) begin
        pkt[base + i] = byte_t'(rand_next() >> 24);
      end
      if (good_hdr && !bad_sync) begin
        if (req) begin
          exp_q.push_back({1'b1, addr, ptt, model_regs[addr]});
        end
        model_regs[addr] = data;
        model_ptt        = ptt;
      end else begin
        probe_pending = 1'b1;
        probe_addr    = addr;
      end
    end
  endtask

  task automatic build_discovery();
    pkt_len = 8 + int'(rand_next() >> 27);
    for (int i = 0; i < pkt_len; i++) begin
      pkt[i] = byte_t'(rand_next() >> 24);
    end
    pkt[0] = `HL_MAGIC0;
    pkt[1] = `HL_MAGIC1;
    pkt[2] = `HL_TYPE_DISC;
  endtask

  // Levels must follow byte 3 within three cycles
  task automatic send_start(input logic [1:0] flags);
    int n;
    pkt_len    = 4;
    pkt[0]     = `HL_MAGIC0;
    pkt[1]     = `HL_MAGIC1;
    pkt[2]     = `HL_TYPE_START;
    pkt[3]     = {6'd0, flags};
    model_run  = flags[0];
    model_wide = flags[1];
    drive_packet();
    n = 0;
    while ((run_o != model_run || wide_spectrum_o != model_wide) && n < 3) begin
      @(negedge clk_ctrl);
      n++;
    end
    check_value("run_o", 64'(run_o), 64'(model_run));
    check_value("wide_spectrum_o", 64'(wide_spectrum_o), 64'(model_wide));
  endtask

  task automatic check_after_packet();
    int n;
    n = 0;
    while ((exp_q.size() != 0 || disc_seen != disc_expected) && n < WAIT_MAX) begin
      @(negedge clk_ctrl);
      n++;
    end
    // A few more cycles to catch stray pulses
    repeat (2) @(negedge clk_ctrl);
    assert (exp_q.size() == 0) else begin
      stop_with_failure($sformatf("Timed out waiting for %0d expected responses",
                                  exp_q.size()));
    end
    check_value("discovery_o pulse count", 64'(disc_seen), 64'(disc_expected));
    check_value("run_o", 64'(run_o), 64'(model_run));
    check_value("wide_spectrum_o", 64'(wide_spectrum_o), 64'(model_wide));
    check_value("tx_on_o", 64'(tx_on_o), 64'(model_ptt & model_run));
  endtask

  ////////////////////
  // Main sequence

  initial begin
    logic [31:0] r;
    int          wd_count;
    clk_ctrl        = 1'b0;
    rst_i           = 1'b1;
    udp_rx_active_i = 1'b0;
    udp_rx_data_i   = '0;
    lcg_state       = 32'd16;
    model_run       = 1'b0;
    model_wide      = 1'b0;
    model_ptt       = 1'b0;
    disc_seen       = 0;
    disc_expected   = 0;
    probe_pending   = 1'b0;
    probe_addr      = '0;
    for (int i = 0; i < `HL_NUM_REGS; i++) begin
      model_regs[i] = '0;
    end

    repeat (4) begin
      @(posedge clk_ctrl);
      #1;
      check_outputs_low();
    end
    rst_i = 1'b0;
    @(negedge clk_ctrl);
    check_outputs_low();

    r = rand_next();
    send_start({r[31], 1'b1});
    check_after_packet();

    // Optional side packet then a good data packet to reload the watchdog
    for (int iter = 0; iter < 16; iter++) begin
      r = rand_next();
      case (r[31:30])
        2'd1: begin
          build_data(1'b0);
          drive_packet();
          check_after_packet();
        end
        2'd2: begin
          build_discovery();
          disc_expected++;
          drive_packet();
          check_after_packet();
        end
        2'd3: begin
          send_start(r[29:28]);
          check_after_packet();
        end
        default: begin
        end
      endcase
      build_data(1'b1);
      drive_packet();
      check_after_packet();
    end

    // Watchdog with no further traffic, wide spectrum has to survive it
    send_start(2'b11);
    wd_count = 0;
    while (run_o && wd_count <= WD + 8) begin
      @(negedge clk_ctrl);
      wd_count++;
    end
    assert (!run_o) else begin
      stop_with_failure("run_o never fell after the watchdog period");
    end
    assert (wd_count >= WD && wd_count <= WD + 4) else begin
      stop_with_failure($sformatf("[FAIL] time %0t: watchdog cycles = %0d, expected %0d to %0d",
                                  $time, wd_count, WD, WD + 4));
    end
    model_run = 1'b0;
    check_after_packet();

    $display("Test passed");
    $finish;
  end

endmodule

/* hl_ctrl_top.sv */
/*
  Control path top level. Chains classifier, command extractor and
  command registers on clk_ctrl.
*/
`timescale 1ns/1ps

module hl_ctrl_top (
  input  logic          clk_ctrl,
  input  logic          rst_i,
  input  logic          udp_rx_active_i,
  input  hl_pkg::byte_t udp_rx_data_i,
  output logic          run_o,
  output logic          wide_spectrum_o,
  output logic          discovery_o,
  output logic          tx_on_o,
  output hl_pkg::resp_t resp_o,
  output logic          resp_rqst_o
);

  import hl_pkg::*;

  frame_byte_t fb;
  cmd_t        cmd;

  hl_packet_classifier i_hl_packet_classifier (
    .clk_ctrl        (clk_ctrl),
    .rst_i           (rst_i),
    .udp_rx_active_i (udp_rx_active_i),
    .udp_rx_data_i   (udp_rx_data_i),
    .fb_o            (fb),
    .run_o           (run_o),
    .wide_spectrum_o (wide_spectrum_o),
    .discovery_o     (discovery_o)
  );

  hl_cmd_extractor i_hl_cmd_extractor (
    .clk_ctrl (clk_ctrl),
    .rst_i    (rst_i),
    .fb_i     (fb),
    .cmd_o    (cmd)
  );

  hl_cmd_regs i_hl_cmd_regs (
    .clk_ctrl    (clk_ctrl),
    .rst_i       (rst_i),
    .cmd_i       (cmd),
    .run_i       (run_o),
    .tx_on_o     (tx_on_o),
    .resp_o      (resp_o),
    .resp_rqst_o (resp_rqst_o)
  );

endmodule

/* hl_cmd_regs.sv */
/*
  Last pipeline stage. Command register bank with read-before-write,
  PTT latch gated by run, and the registered response with its request pulse.
*/
`timescale 1ns/1ps
`include "hl_cfg.svh"

module hl_cmd_regs (
  input  logic          clk_ctrl,
  input  logic          rst_i,
  input  hl_pkg::cmd_t  cmd_i,
  input  logic          run_i,
  output logic          tx_on_o,
  output hl_pkg::resp_t resp_o,
  output logic          resp_rqst_o
);

  import hl_pkg::*;

  cmd_data_t regs_q [`HL_NUM_REGS];
  logic      ptt_q;
  logic      resp_hit;

  assign resp_hit = cmd_i.valid && cmd_i.resp_req;

  ////////////////////
  // Register bank and PTT

  always_ff @(posedge clk_ctrl) begin
    if (rst_i) begin
      for (int i = 0; i < `HL_NUM_REGS; i++) begin
        regs_q[i] <= '0;
      end
      ptt_q       <= 1'b0;
      resp_rqst_o <= 1'b0;
    end else begin
      resp_rqst_o <= resp_hit;
      if (cmd_i.valid) begin
        regs_q[cmd_i.addr] <= cmd_i.data;
        ptt_q              <= cmd_i.ptt;
      end
    end
  end

  ////////////////////
  // Response

  // Old register contents go back, the write lands on the same edge
  always_ff @(posedge clk_ctrl) begin
    if (resp_hit) begin
      resp_o.mark <= 1'b1;
      resp_o.addr <= cmd_i.addr;
      resp_o.ptt  <= cmd_i.ptt;
      resp_o.data <= regs_q[cmd_i.addr];
    end
  end

  // Drops together with run, no extra register
  assign tx_on_o = ptt_q & run_i;

endmodule

/* hl_cmd_extractor.sv */
/*
  Second pipeline stage. Checks the three sync bytes of every USB frame,
  collects C0..C4 and emits one command per frame with good sync.
*/
`timescale 1ns/1ps
`include "hl_cfg.svh"

module hl_cmd_extractor (
  input  logic                clk_ctrl,
  input  logic                rst_i,
  input  hl_pkg::frame_byte_t fb_i,
  output hl_pkg::cmd_t        cmd_o
);

  import hl_pkg::*;

  ext_state_e  state_q;
  logic [31:0] ctl_q;
  byte_t       c0;
  logic        c4_hit;

  // C0..C3 shifted in, C0 ends on top
  assign c0 = ctl_q[31:24];

  assign c4_hit = fb_i.valid && (state_q == EXT_CONTROL) &&
                  (fb_i.pos == frame_pos_t'(7));

  ////////////////////
  // Sync check FSM

  always_ff @(posedge clk_ctrl) begin
    if (rst_i) begin
      state_q <= EXT_DROP;
    end else if (fb_i.valid) begin
      if (fb_i.pos == '0) begin
        // Every frame gets a fresh start
        state_q <= (fb_i.data == `HL_SYNC_BYTE) ? EXT_SYNC : EXT_DROP;
      end else begin
        case (state_q)
          EXT_SYNC: begin
            if (fb_i.data != `HL_SYNC_BYTE) begin
              state_q <= EXT_DROP;
            end else if (fb_i.pos == frame_pos_t'(2)) begin
              state_q <= EXT_CONTROL;
            end
          end
          EXT_CONTROL: begin
            if (fb_i.pos == frame_pos_t'(7)) begin
              state_q <= EXT_PAYLOAD;
            end
          end
          default: begin
            // IQ payload or a bad frame, nothing to do until pos 0
            state_q <= state_q;
          end
        endcase
      end
    end
  end

  // Control bytes holding register
  always_ff @(posedge clk_ctrl) begin
    if (fb_i.valid && (state_q == EXT_CONTROL)) begin
      ctl_q <= {ctl_q[23:0], fb_i.data};
    end
  end

  ////////////////////
  // Command output

  always_ff @(posedge clk_ctrl) begin
    if (rst_i) begin
      cmd_o <= '0;
    end else begin
      cmd_o.valid    <= c4_hit;
      cmd_o.resp_req <= c0[7];
      cmd_o.addr     <= c0[6:1];
      cmd_o.ptt      <= c0[0];
      // C4 comes straight from the input, C1 is the MSB
      cmd_o.data     <= {ctl_q[23:0], fb_i.data};
    end
  end

endmodule

/* hl_packet_classifier.sv */
/*
  First pipeline stage. Checks the header of each UDP payload, labels the
  bytes of both USB frames of a data packet with their frame offset, and
  owns the run, wide-spectrum, discovery and watchdog state.
*/
`timescale 1ns/1ps
`include "hl_cfg.svh"

module hl_packet_classifier (
  input  logic                clk_ctrl,
  input  logic                rst_i,
  input  logic                udp_rx_active_i,
  input  hl_pkg::byte_t       udp_rx_data_i,
  output hl_pkg::frame_byte_t fb_o,
  output logic                run_o,
  output logic                wide_spectrum_o,
  output logic                discovery_o
);

  import hl_pkg::*;

  // Index of the last USB frame byte in a data packet
  localparam int unsigned PAYLOAD_END = `HL_HDR_LEN + `HL_NUM_FRAMES * `HL_FRAME_LEN - 1;

  cls_state_e  state_q;
  logic [10:0] byte_idx_q;
  logic [10:0] payload_off;
  wd_cnt_t     wd_cnt_q;
  logic        wd_expired;
  logic        hdr_data_ok;
  logic        start_byte;

  assign payload_off = byte_idx_q - 11'(`HL_HDR_LEN);
  assign wd_expired  = (wd_cnt_q == wd_cnt_t'(`HL_WATCHDOG_CYCLES - 1));

  // Endpoint byte of a data packet matches
  assign hdr_data_ok = udp_rx_active_i && (state_q == CLS_HEADER) &&
                       (byte_idx_q == 11'd3) && (udp_rx_data_i == `HL_EP_DATA);

  // Run and wide spectrum flags sit in byte 3
  assign start_byte = udp_rx_active_i && (state_q == CLS_START) && (byte_idx_q == 11'd3);

  ////////////////////
  // Header FSM

  always_ff @(posedge clk_ctrl) begin
    if (rst_i) begin
      state_q     <= CLS_IDLE;
      byte_idx_q  <= '0;
      discovery_o <= 1'b0;
    end else begin
      discovery_o <= 1'b0;
      if (!udp_rx_active_i) begin
        byte_idx_q <= '0;
        state_q    <= CLS_IDLE;
        // Reply only once the whole discovery packet is in
        if (state_q == CLS_DISC) begin
          discovery_o <= 1'b1;
        end
      end else begin
        byte_idx_q <= byte_idx_q + 11'd1;
        case (state_q)
          CLS_IDLE: begin
            state_q <= (udp_rx_data_i == `HL_MAGIC0) ? CLS_HEADER : CLS_SKIP;
          end
          CLS_HEADER: begin
            if (byte_idx_q == 11'd1) begin
              if (udp_rx_data_i != `HL_MAGIC1) begin
                state_q <= CLS_SKIP;
              end
            end else if (byte_idx_q == 11'd2) begin
              case (udp_rx_data_i)
                `HL_TYPE_DATA:  state_q <= CLS_HEADER;
                `HL_TYPE_DISC:  state_q <= CLS_DISC;
                `HL_TYPE_START: state_q <= CLS_START;
                default:        state_q <= CLS_SKIP;
              endcase
            end else begin
              // Only data packets are still here at byte 3
              state_q <= hdr_data_ok ? CLS_FRAMES : CLS_SKIP;
            end
          end
          CLS_FRAMES: begin
            if (byte_idx_q == 11'(PAYLOAD_END)) begin
              state_q <= CLS_SKIP;
            end
          end
          CLS_START: begin
            if (byte_idx_q == 11'd3) begin
              state_q <= CLS_SKIP;
            end
          end
          default: begin
            // Discovery and skip wait for the end of the packet
            state_q <= state_q;
          end
        endcase
      end
    end
  end

  ////////////////////
  // Frame byte output

  // Sequence number bytes 4..7 never reach the extractor
  always_ff @(posedge clk_ctrl) begin
    if (rst_i) begin
      fb_o <= '0;
    end else begin
      fb_o.valid <= udp_rx_active_i && (state_q == CLS_FRAMES) &&
                    (byte_idx_q >= 11'(`HL_HDR_LEN));
      fb_o.data  <= udp_rx_data_i;
      fb_o.pos   <= frame_pos_t'(payload_off % `HL_FRAME_LEN);
      fb_o.first <= (payload_off < 11'(`HL_FRAME_LEN));
    end
  end

  ////////////////////
  // Run and watchdog

  always_ff @(posedge clk_ctrl) begin
    if (rst_i) begin
      run_o           <= 1'b0;
      wide_spectrum_o <= 1'b0;
      wd_cnt_q        <= '0;
    end else begin
      if (start_byte) begin
        run_o           <= udp_rx_data_i[0];
        wide_spectrum_o <= udp_rx_data_i[1];
        wd_cnt_q        <= '0;
      end else if (hdr_data_ok || !run_o) begin
        wd_cnt_q <= '0;
      end else if (wd_expired) begin
        // Host went quiet, stop; wide spectrum is left alone
        run_o    <= 1'b0;
        wd_cnt_q <= '0;
      end else begin
        wd_cnt_q <= wd_cnt_q + wd_cnt_t'(1);
      end
    end
  end

endmodule

/* hl_pkg.sv */
/*
  Shared types for the control path. Modules refer to these by scoped
  names in their port lists and import the package in their bodies.
*/
package hl_pkg;

  // Widths with a meaning
  typedef logic [7:0]  byte_t;
  typedef logic [9:0]  frame_pos_t;
  typedef logic [5:0]  cmd_addr_t;
  typedef logic [31:0] cmd_data_t;
  typedef logic [11:0] wd_cnt_t;

  // Payload byte handed from classifier to extractor
  typedef struct packed {
    logic       valid;
    byte_t      data;
    frame_pos_t pos;
    logic       first;
  } frame_byte_t;

  // One decoded command, C0 fields plus C1..C4 data
  typedef struct packed {
    logic      valid;
    logic      resp_req;
    cmd_addr_t addr;
    logic      ptt;
    cmd_data_t data;
  } cmd_t;

  // Response word, header byte first
  typedef struct packed {
    logic      mark;
    cmd_addr_t addr;
    logic      ptt;
    cmd_data_t data;
  } resp_t;

  typedef enum logic [2:0] {
    CLS_IDLE,
    CLS_HEADER,
    CLS_FRAMES,
    CLS_START,
    CLS_DISC,
    CLS_SKIP
  } cls_state_e;

  typedef enum logic [1:0] {
    EXT_SYNC,
    EXT_CONTROL,
    EXT_PAYLOAD,
    EXT_DROP
  } ext_state_e;

endpackage

/* hl_cfg.svh */
/*
  Constants for the control path: packet header bytes, USB frame layout,
  register bank size and watchdog length. Include in any module that needs them.
*/
`ifndef HL_CFG_SVH
`define HL_CFG_SVH

// Packet header
`define HL_MAGIC0          8'hEF
`define HL_MAGIC1          8'hFE
`define HL_TYPE_DATA       8'h01
`define HL_TYPE_DISC       8'h02
`define HL_TYPE_START      8'h04
`define HL_EP_DATA         8'h02

// USB frame layout inside a data packet
`define HL_SYNC_BYTE       8'h7F
`define HL_HDR_LEN         8
`define HL_FRAME_LEN       512
`define HL_NUM_FRAMES      2

// Command registers and run watchdog
`define HL_NUM_REGS        64
`define HL_WATCHDOG_CYCLES 4000

`endif
